//--- dv/tb_top.sv
/*
 Testbench for the int8 matrix-multiply engine
   clock, reset and load sequencing tasks
   reference matrix product modulo 2^16
   row checks by immediate assertions
   control rules by concurrent assertions
*/

`timescale 1ns/1ps

module tb_top
import mini_core_accel_pkg::*;
();

    logic     clk;
    logic     arst_n;
    logic     start;
    logic     load;
    lane_t    a_col;     // Lane r holds A[r][k]
    lane_t    w_row;     // Lane c holds W[k][c]
    row_idx_t rd_row;
    res_row_t rd_data;
    logic     busy;
    logic     mm_done;

    int8_t mat_a [DIM][DIM];  // Activations A[r][k]
    int8_t mat_w [DIM][DIM];  // Weights W[k][c]
    acc_t  mat_c [DIM][DIM];  // Expected C[r][c]

    mca_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    // Next rising edge plus the drive delay
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic fill_random();
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                mat_a[i][j] = int8_t'($urandom_range(255, 0));
                mat_w[i][j] = int8_t'($urandom_range(255, 0));
            end
        end
    endtask

    // C = A x W in full integer precision and cut to 16 bits
    function automatic void compute_reference();
        int sum;
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                sum = 0;
                for (int k = 0; k < DIM; k++) begin
                    sum += int'(mat_a[r][k]) * int'(mat_w[k][c]);
                end
                mat_c[r][c] = acc_t'(sum);  // Modulo 2^16
            end
        end
    endfunction

    // One operation with optional idle gaps and strobes that must be ignored
    task automatic run_mm(input int max_gap, input bit disturb);
        int waited;
        step();
        start = 1'b1;
        step();
        start = 1'b0;
        assert (busy === 1'b1) else begin
            $display("ERR busy expected %h actual %h after start", 1'b1, busy);
            abort_run();
        end
        step();  // Clear cycle
        for (int k = 0; k < DIM; k++) begin
            repeat ($urandom_range(max_gap, 0)) begin
                start = disturb;  // Start while loading
                step();
            end
            start = 1'b0;
            load  = 1'b1;
            for (int i = 0; i < DIM; i++) begin
                a_col[i] = mat_a[i][k];  // Column k of A
                w_row[i] = mat_w[k][i];  // Row k of W
            end
            step();
            load = 1'b0;
        end
        if (disturb) begin
            // Junk strobes for two cycles once drain has begun
            load  = 1'b1;
            start = 1'b1;
            a_col = '1;
            w_row = '1;
            step();
            step();
            load  = 1'b0;
            start = 1'b0;
        end
        waited = 0;
        while (mm_done !== 1'b1) begin
            if (waited == 100) begin
                $display("Timeout: mm_done did not arrive within 100 cycles");
                abort_run();
            end
            step();
            waited++;
        end
        for (int i = 0; i < 12; i++) begin
            step();
            if (mm_done !== 1'b0) begin
                $display("A second mm_done pulse followed the first one");
                abort_run();
            end
        end
    endtask

    // Every row of the bank against the expected matrix
    task automatic check_results();
        res_row_t exp_row;
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                exp_row[c] = mat_c[r][c];
            end
            step();
            rd_row = row_idx_t'(r);
            #5;  // Combinational read settles
            assert (rd_data === exp_row) else begin
                $display("ERR rd_data row %0d expected %h actual %h", r, exp_row, rd_data);
                abort_run();
            end
        end
    endtask

    reset_quiet: assert property (@(posedge clk) !arst_n |-> (!busy && !mm_done))
        else begin
            $display("busy or mm_done was high while reset was applied");
            abort_run();
        end

    done_pulse: assert property (@(posedge clk) disable iff (!arst_n) mm_done |=> !mm_done)
        else begin
            $display("mm_done stayed high for more than one cycle");
            abort_run();
        end

    busy_fall: assert property (@(posedge clk) disable iff (!arst_n)
                                mm_done |-> (!busy && $past(busy)))
        else begin
            $display("busy did not fall in the cycle of mm_done");
            abort_run();
        end

    initial begin
        void'($urandom(32'he8f5));  // One seed for the run
        arst_n = 1'b0;
        start  = 1'b0;
        load   = 1'b0;
        a_col  = '0;
        w_row  = '0;
        rd_row = '0;
        repeat (16) @(posedge clk);
        #2;
        arst_n = 1'b1;

        // Idle outputs and an empty bank
        assert (busy === 1'b0 && mm_done === 1'b0) else begin
            $display("ERR busy/mm_done expected 0/0 actual %h/%h", busy, mm_done);
            abort_run();
        end
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                mat_c[r][c] = '0;
            end
        end
        check_results();

        // Identity W gives A sign-extended
        fill_random();
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                mat_w[r][c] = int8_t'(r == c);
                mat_c[r][c] = {{8{mat_a[r][c][7]}}, mat_a[r][c]};
            end
        end
        run_mm(0, 1'b0);
        check_results();

        // Random with both limits present
        fill_random();
        mat_a[0][0] = int8_t'(-128);
        mat_w[0][0] = int8_t'(-128);
        mat_a[3][2] = 8'sd127;
        mat_w[2][3] = int8_t'(-128);
        mat_a[1][3] = 8'sd127;
        mat_w[3][1] = 8'sd127;
        compute_reference();
        run_mm(0, 1'b0);
        check_results();

        // All -128 so every sum of 65536 wraps to zero and any residue shows
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                mat_a[r][c] = int8_t'(-128);
                mat_w[r][c] = int8_t'(-128);
            end
        end
        compute_reference();
        run_mm(0, 1'b0);
        check_results();

        // Same operands back to back and then with gaps
        fill_random();
        compute_reference();
        run_mm(0, 1'b0);
        check_results();
        run_mm(6, 1'b0);
        check_results();

        // Stray start and load strobes while busy
        fill_random();
        compute_reference();
        run_mm(4, 1'b1);
        check_results();

        for (int n = 0; n < 4; n++) begin
            fill_random();
            compute_reference();
            run_mm(3, 1'b0);
            check_results();
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- hdl/matmul_ctrl.sv
/*
 Controller of the matrix-multiply engine
   FSM over idle, clear, load, drain and done
   load counter and load gating into the skewers
   clear, first_done, cap and mm_done pulses plus the busy level
*/

`timescale 1ns/1ps

module matmul_ctrl
import mini_core_accel_pkg::*;
(
    input  logic clk,
    input  logic arst_n,
    input  logic start,       // Accepted in idle or done only
    input  logic load,        // Accepted in load only
    input  logic valid,       // From the array
    output logic shift_en,    // Accepted load, skewers take the lanes
    output logic arr_clear,   // Zero the accumulators
    output logic first_done,  // Starts the done wavefront
    output logic cap,         // Result bank capture
    output logic busy,
    output logic mm_done      // Single-cycle completion
);

    ctrl_state_e      state;
    ctrl_state_e      state_nxt;
    logic [IDX_W-1:0] load_cnt;      // Accepted loads so far
    logic             last_load;     // Accepted load number DIM
    logic             first_done_q;
    logic             mm_done_q;

    assign shift_en  = load && (state == ST_LOAD);
    assign last_load = shift_en && (load_cnt == IDX_W'(DIM - 1));
    assign arr_clear = (state == ST_CLEAR);
    assign cap       = valid && (state == ST_DRAIN);   // Results are final now
    assign busy      = (state == ST_CLEAR) || (state == ST_LOAD) || (state == ST_DRAIN);

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE,
            ST_DONE:  if (start) state_nxt = ST_CLEAR;
            ST_CLEAR: state_nxt = ST_LOAD;
            ST_LOAD:  if (last_load) state_nxt = ST_DRAIN;
            ST_DRAIN: if (valid) state_nxt = ST_DONE;
            default:  state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= ST_IDLE;
            load_cnt     <= '0;
            first_done_q <= 1'b0;
            mm_done_q    <= 1'b0;
        end else begin
            state        <= state_nxt;
            first_done_q <= last_load;  // First cycle of drain
            mm_done_q    <= cap;        // Cycle after capture, busy already low
            if (state == ST_CLEAR) begin
                load_cnt <= '0;
            end else if (shift_en) begin
                load_cnt <= load_cnt + 1'b1;
            end
        end
    end

    assign first_done = first_done_q;
    assign mm_done    = mm_done_q;

endmodule

//--- hdl/mca_top.sv
/*
 Top level of the int8 matrix-multiply engine
   controller, activation and weight skewers
   systolic array and result bank
*/

`timescale 1ns/1ps

module mca_top
import mini_core_accel_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     start,    // Pulse, begins one operation
    input  logic     load,     // Strobe with a_col and w_row
    input  lane_t    a_col,    // Column k of A, lane r holds A[r][k]
    input  lane_t    w_row,    // Row k of W, lane c holds W[k][c]
    input  row_idx_t rd_row,
    output res_row_t rd_data,
    output logic     busy,
    output logic     mm_done   // Pulse, results readable
);

    logic               shift_en;
    logic               arr_clear;
    logic               first_done;
    logic               cap;
    logic               valid;
    lane_t              act_skewed;  // Into the left column
    lane_t              wgt_skewed;  // Into the top row
    acc_t [DIM*DIM-1:0] results;

    matmul_ctrl ctrl0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .load       (load),
        .valid      (valid),
        .shift_en   (shift_en),
        .arr_clear  (arr_clear),
        .first_done (first_done),
        .cap        (cap),
        .busy       (busy),
        .mm_done    (mm_done)
    );

    // Activations
    operand_skewer act_skew0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .shift_en (shift_en),
        .lane_in  (a_col),
        .lane_out (act_skewed)
    );

    // Weights
    operand_skewer wgt_skew0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .shift_en (shift_en),
        .lane_in  (w_row),
        .lane_out (wgt_skewed)
    );

    systolic_array_net array0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .weights    (wgt_skewed),
        .activation (act_skewed),
        .clear      (arr_clear),
        .first_done (first_done),
        .results    (results),
        .valid      (valid)
    );

    result_bank bank0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .cap     (cap),
        .results (results),
        .rd_row  (rd_row),
        .rd_data (rd_data)
    );

endmodule

//--- hdl/mini_core_accel_pkg.sv
/*
 Shared definitions for the int8 matrix-multiply engine
   array dimension and index width
   operand, accumulator, lane and result row types
   PE input and output structs
   controller state encoding
*/

package mini_core_accel_pkg;

    localparam int DIM   = 4;           // Array side length
    localparam int IDX_W = $clog2(DIM); // Bits to index a row or a load

    // Scalar types
    typedef logic signed [7:0]  int8_t;  // One weight or activation
    typedef logic signed [15:0] acc_t;   // One accumulator or result

    // One operand column or row, element i in lane i
    typedef int8_t [DIM-1:0] lane_t;

    // One row of results, element c in lane c
    typedef acc_t [DIM-1:0] res_row_t;

    typedef logic [IDX_W-1:0] row_idx_t; // Result row select

    // Everything a PE takes in on one cycle
    typedef struct packed {
        int8_t weight;      // From the PE above or the weight skewer
        int8_t activation;  // From the PE to the left or the activation skewer
        logic  clear;       // Zero the accumulator
        logic  done;        // Wavefront flag
    } pe_in_t;

    // Registered copies handed on to the neighbors
    typedef struct packed {
        int8_t weight;      // Goes down
        int8_t activation;  // Goes right
        logic  done;        // Goes down and right
    } pe_out_t;

    // Controller sequence
    typedef enum logic [2:0] {
        ST_IDLE,   // Waiting for start
        ST_CLEAR,  // One cycle of accumulator clear
        ST_LOAD,   // Taking DIM load strobes
        ST_DRAIN,  // Waiting for the done wavefront to reach the last PE
        ST_DONE    // Results captured and held
    } ctrl_state_e;

endpackage

//--- hdl/operand_skewer.sv
/*
 Triangular operand skewer
   lane i delayed by i cycles, lane 0 passes straight through
   zero lane injected while shift_en is low
*/

`timescale 1ns/1ps

module operand_skewer
import mini_core_accel_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  shift_en,  // Lane input is taken only when high
    input  lane_t lane_in,
    output lane_t lane_out   // Staggered by lane index
);

    lane_t lane_gated;  // Input lane or zeros

    assign lane_gated = shift_en ? lane_in : '0;

    for (genvar i = 0; i < DIM; i++) begin : g_lane
        if (i == 0) begin : g_direct
            assign lane_out[i] = lane_gated[i];  // No delay for the first lane
        end else begin : g_delay
            int8_t taps [i];  // i stages for lane i

            // Shifts every cycle so gaps keep the lanes aligned
            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    for (int j = 0; j < i; j++) taps[j] <= '0;
                end else begin
                    taps[0] <= lane_gated[i];
                    for (int j = 1; j < i; j++) taps[j] <= taps[j-1];
                end
            end

            assign lane_out[i] = taps[i-1];  // Oldest stage
        end
    end

endmodule

//--- hdl/pe_unit.sv
/*
 Processing element of the systolic array
   signed 8x8 multiply-accumulate into a 16-bit wrapping accumulator
   one-cycle forwarding of weight, activation and done flag
*/

`timescale 1ns/1ps

module pe_unit
import mini_core_accel_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  pe_in_t  pe_inputs,   // Operands, clear and done from the neighbors
    output pe_out_t pe_outputs,  // Registered operands and done for the neighbors
    output acc_t    result       // Running dot product
);

    acc_t acc;      // Accumulator
    acc_t product;  // Current weight times activation

    // Both operands sign-extended before the multiply so the product is exact
    assign product = acc_t'(pe_inputs.weight) * acc_t'(pe_inputs.activation);

    // Clear wins over accumulate
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc <= '0;
        end else if (pe_inputs.clear) begin
            acc <= '0;
        end else begin
            acc <= acc + product;  // Wraps modulo 2^16
        end
    end

    // Operands and the done flag move one PE per cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pe_outputs <= '0;
        end else begin
            pe_outputs.weight     <= pe_inputs.weight;
            pe_outputs.activation <= pe_inputs.activation;
            pe_outputs.done       <= pe_inputs.done;
        end
    end

    assign result = acc;

endmodule

//--- hdl/result_bank.sv
/*
 Result bank
   captures all array results on cap
   combinational row read, element c in lane c
*/

`timescale 1ns/1ps

module result_bank
import mini_core_accel_pkg::*;
(
    input  logic               clk,
    input  logic               arst_n,
    input  logic               cap,      // Store the array results
    input  acc_t [DIM*DIM-1:0] results,  // Row-major from the array
    input  row_idx_t           rd_row,
    output res_row_t           rd_data
);

    acc_t [DIM*DIM-1:0] bank;  // Held until the next capture

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bank <= '0;  // Reads zero after reset
        end else if (cap) begin
            bank <= results;
        end
    end

    // Row select
    always_comb begin
        for (int c = 0; c < DIM; c++) begin
            rd_data[c] = bank[int'(rd_row) * DIM + c];
        end
    end

endmodule

//--- hdl/systolic_array_net.sv
/*
 DIMxDIM output-stationary systolic array
   weights flow down the columns, activations flow right along the rows
   done wavefront from PE00 toward the last PE
   flat row-major result vector and the array valid strobe
*/

`timescale 1ns/1ps

module systolic_array_net
import mini_core_accel_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  lane_t                  weights,     // Row 0 weights, lane c to column c
    input  lane_t                  activation,  // Column 0 activations, lane r to row r
    input  logic                   clear,       // Zero every accumulator
    input  logic                   first_done,  // Done flag into PE00
    output acc_t [DIM*DIM-1:0]     results,     // Element r*DIM+c from PE[r][c]
    output logic                   valid        // Last PE has its final operands
);

    pe_in_t  unit_in  [DIM][DIM];  // Inputs of every PE
    pe_out_t unit_out [DIM][DIM];  // Registered outputs of every PE

    for (genvar row = 0; row < DIM; row++) begin : g_row
        for (genvar col = 0; col < DIM; col++) begin : g_col

            // Weight from the port on the top row, else from above
            if (row == 0) begin : g_w_port
                assign unit_in[row][col].weight = weights[col];
            end else begin : g_w_above
                assign unit_in[row][col].weight = unit_out[row-1][col].weight;
            end

            // Activation from the port on the left column, else from the left
            if (col == 0) begin : g_a_port
                assign unit_in[row][col].activation = activation[row];
            end else begin : g_a_left
                assign unit_in[row][col].activation = unit_out[row][col-1].activation;
            end

            assign unit_in[row][col].clear = clear;  // Broadcast

            // Done wavefront, same skew as the data
            if (row == 0 && col == 0) begin : g_d_origin
                assign unit_in[row][col].done = first_done;
            end else if (row == 0) begin : g_d_left
                assign unit_in[row][col].done = unit_out[row][col-1].done;
            end else if (col == 0) begin : g_d_above
                assign unit_in[row][col].done = unit_out[row-1][col].done;
            end else begin : g_d_both
                // Both neighbors carry the flag in the same cycle
                assign unit_in[row][col].done = unit_out[row-1][col].done |
                                                unit_out[row][col-1].done;
            end

            pe_unit pe_inst (
                .clk        (clk),
                .arst_n     (arst_n),
                .pe_inputs  (unit_in[row][col]),
                .pe_outputs (unit_out[row][col]),
                .result     (results[row*DIM+col])
            );
        end
    end

    // Flag at the input of the last PE
    assign valid = unit_in[DIM-1][DIM-1].done;

endmodule

//--- run.sh
#!/bin/sh
# Build and run the matrix-multiply testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "PASS: all tests" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- tb.f
hdl/mini_core_accel_pkg.sv
hdl/pe_unit.sv
hdl/operand_skewer.sv
hdl/systolic_array_net.sv
hdl/matmul_ctrl.sv
hdl/result_bank.sv
hdl/mca_top.sv
dv/tb_top.sv
